//--- core_pkg.sv
// ##############################
// core package
// shared types for the multi-cycle RV32I subset core, its buses
// and its retire port
// ##############################
`default_nettype none

package core_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // RV32I major opcodes in the supported subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } rv_opcode_e;

  localparam xlen_t EBREAK_WORD = 32'h0010_0073;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_HALT, CLS_ILLEGAL
  } inst_class_e;

  typedef enum logic [2:0] {
    ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK, ST_HALT, ST_ERROR
  } ctrl_state_e;

  // 56 bits
  typedef struct packed {
    inst_class_e cls;
    alu_op_e     alu_op;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    xlen_t       imm;
    logic        imm_sel;
    logic        bne;
    logic        wen;
  } micro_op_t;

  // wishbone classic master side, 71 bits
  typedef struct packed {
    xlen_t      adr;
    xlen_t      dat;
    logic [3:0] sel;
    logic       we;
    logic       cyc;
    logic       stb;
  } wb_req_t;

  typedef struct packed {
    xlen_t dat;
    logic  ack;
  } wb_rsp_t;

  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    reg_idx_t rd;
    xlen_t    wdata;
    logic     wen;
  } retire_t;

endpackage

`default_nettype wire

//--- alu.sv
// ##############################
// integer alu
// arithmetic, logic, signed compare and branch equality
// ##############################
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire core_pkg::alu_op_e op,
  input  wire core_pkg::xlen_t   a,
  input  wire core_pkg::xlen_t   b,
  output core_pkg::xlen_t        result,
  output logic                   equal
);
  import core_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      // signed compare, result is 0 or 1
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // branch compare runs on the raw operands
  assign equal = (a == b);

endmodule

`default_nettype wire

//--- reg_file.sv
// ##############################
// integer register file
// 32 x 32, two async read ports, one write port, x0 tied to zero
// ##############################
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic               clock,
  input  wire logic               rst_n,
  input  wire core_pkg::reg_idx_t rs1_idx,
  input  wire core_pkg::reg_idx_t rs2_idx,
  input  wire logic               wen,
  input  wire core_pkg::reg_idx_t rd_idx,
  input  wire core_pkg::xlen_t    wdata,
  output core_pkg::xlen_t         rs1_data,
  output core_pkg::xlen_t         rs2_data
);
  import core_pkg::*;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd_idx != '0) begin
      regs[rd_idx] <= wdata;
    end
  end

  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  a_x0_zero: assert property (@(posedge clock) disable iff (!rst_n)
    (rs1_idx != '0 || rs1_data == '0) && (rs2_idx != '0 || rs2_data == '0));

endmodule

`default_nettype wire

//--- inst_decode.sv
// ##############################
// instruction decode
// turns an RV32I word into a micro-op with immediate and alu opcode
// ##############################
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  wire core_pkg::xlen_t inst_word,
  output core_pkg::micro_op_t  uop
);
  import core_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;

  assign funct3 = inst_word[14:12];
  assign funct7 = inst_word[31:25];

  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                  inst_word[30:25], inst_word[11:8], 1'b0};
  assign imm_u = {inst_word[31:12], 12'b0};

  always_comb begin
    uop        = '0;
    uop.cls    = CLS_ILLEGAL;
    uop.alu_op = ALU_ADD;
    uop.rs1    = inst_word[19:15];
    uop.rs2    = inst_word[24:20];
    uop.rd     = inst_word[11:7];
    case (inst_word[6:0])
      OPC_OP: begin
        uop.cls = CLS_ALU;
        uop.wen = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: uop.alu_op = ALU_ADD;
          {7'h20, 3'b000}: uop.alu_op = ALU_SUB;
          {7'h00, 3'b111}: uop.alu_op = ALU_AND;
          {7'h00, 3'b110}: uop.alu_op = ALU_OR;
          {7'h00, 3'b100}: uop.alu_op = ALU_XOR;
          {7'h00, 3'b010}: uop.alu_op = ALU_SLT;
          default: begin
            uop.cls = CLS_ILLEGAL;
            uop.wen = 1'b0;
          end
        endcase
      end
      OPC_OP_IMM: begin
        // addi only
        if (funct3 == 3'b000) begin
          uop.cls     = CLS_ALU;
          uop.imm     = imm_i;
          uop.imm_sel = 1'b1;
          uop.wen     = 1'b1;
        end
      end
      OPC_LUI: begin
        uop.cls     = CLS_ALU;
        uop.alu_op  = ALU_PASS_B;
        uop.imm     = imm_u;
        uop.imm_sel = 1'b1;
        uop.wen     = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          uop.cls     = CLS_LOAD;
          uop.imm     = imm_i;
          uop.imm_sel = 1'b1;
          uop.wen     = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          uop.cls     = CLS_STORE;
          uop.imm     = imm_s;
          uop.imm_sel = 1'b1;
        end
      end
      OPC_BRANCH: begin
        // beq and bne differ only in funct3 bit 0
        if (funct3[2:1] == 2'b00) begin
          uop.cls    = CLS_BRANCH;
          uop.alu_op = ALU_SUB;
          uop.imm    = imm_b;
          uop.bne    = funct3[0];
        end
      end
      OPC_SYSTEM: begin
        if (inst_word == EBREAK_WORD) begin
          uop.cls = CLS_HALT;
        end
      end
      default: uop.cls = CLS_ILLEGAL;
    endcase
    // x0 never takes a result
    if (uop.rd == '0) begin
      uop.wen = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- bus_watchdog.sv
// ##############################
// bus watchdog
// counts unanswered wishbone cycles and flags a stuck slave
// ##############################
`timescale 1ns/1ps
`default_nettype none

module bus_watchdog #(
  parameter int ACK_TIMEOUT = 16
) (
  input  wire logic clock,
  input  wire logic rst_n,
  input  wire logic cyc,
  input  wire logic ack,
  output logic      timeout
);
  localparam int CNT_W = $clog2(ACK_TIMEOUT + 1);

  logic [CNT_W-1:0] wait_cnt;

  // saturates at the limit so the pulse fires only once
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!cyc || ack) begin
      wait_cnt <= '0;
    end else if (wait_cnt != CNT_W'(ACK_TIMEOUT)) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // fires in the last cycle the slave is allowed
  assign timeout = cyc && !ack && (wait_cnt == CNT_W'(ACK_TIMEOUT - 1));

  // one pulse per stuck cycle
  a_single_pulse: assert property (@(posedge clock) disable iff (!rst_n)
    timeout |=> !timeout);

  // the master must give up the bus after a timeout
  a_cyc_dropped: assert property (@(posedge clock) disable iff (!rst_n)
    timeout |=> !cyc);

endmodule

`default_nettype wire

//--- core_ctrl.sv
// ##############################
// core control
// sequences fetch, decode, execute, memory and writeback, owns pc,
// instruction and result registers and drives both wishbone masters
// ##############################
`timescale 1ns/1ps
`default_nettype none

module core_ctrl #(
  parameter core_pkg::xlen_t RESET_PC = '0
) (
  input  wire logic                clock,
  input  wire logic                rst_n,
  input  wire core_pkg::micro_op_t uop,
  input  wire core_pkg::xlen_t     rs1_data,
  input  wire core_pkg::xlen_t     rs2_data,
  input  wire core_pkg::xlen_t     alu_result,
  input  wire logic                alu_equal,
  input  wire core_pkg::wb_rsp_t   ibus_rsp,
  input  wire core_pkg::wb_rsp_t   dbus_rsp,
  input  wire logic                timeout,
  output core_pkg::wb_req_t        ibus_req,
  output core_pkg::wb_req_t        dbus_req,
  output core_pkg::xlen_t          inst_word,
  output logic                     rd_wen,
  output core_pkg::reg_idx_t       rd_idx,
  output core_pkg::xlen_t          rd_wdata,
  output core_pkg::xlen_t          operand_a,
  output core_pkg::xlen_t          operand_b,
  output core_pkg::retire_t        retire,
  output logic                     halted,
  output logic                     bus_error
);
  import core_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;
  xlen_t       pc;
  xlen_t       result;
  xlen_t       store_data;
  logic        ibus_cyc;
  logic        dbus_cyc;
  logic        branch_taken;
  logic        retire_valid;
  logic        ibus_done;
  logic        dbus_done;

  assign ibus_done = ibus_cyc && ibus_rsp.ack;
  assign dbus_done = dbus_cyc && dbus_rsp.ack;

  always_comb begin
    state_next = state;
    case (state)
      ST_FETCH: begin
        if (timeout) begin
          state_next = ST_ERROR;
        end else if (ibus_done) begin
          state_next = ST_DECODE;
        end
      end
      ST_DECODE: begin
        if (uop.cls == CLS_HALT || uop.cls == CLS_ILLEGAL) begin
          state_next = ST_HALT;
        end else begin
          state_next = ST_EXECUTE;
        end
      end
      ST_EXECUTE: begin
        if (uop.cls == CLS_LOAD || uop.cls == CLS_STORE) begin
          state_next = ST_MEMORY;
        end else begin
          state_next = ST_WRITEBACK;
        end
      end
      ST_MEMORY: begin
        if (timeout) begin
          state_next = ST_ERROR;
        end else if (dbus_done) begin
          state_next = ST_WRITEBACK;
        end
      end
      ST_WRITEBACK: state_next = ST_FETCH;
      // halt and error are left only by reset
      default: state_next = state;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state        <= ST_FETCH;
      pc           <= RESET_PC;
      ibus_cyc     <= 1'b0;
      dbus_cyc     <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      state    <= state_next;
      // request rises with the state entry and drops the cycle after ack
      ibus_cyc <= (state_next == ST_FETCH);
      dbus_cyc <= (state_next == ST_MEMORY);
      // ebreak retires on its way into halt
      retire_valid <= (state_next == ST_WRITEBACK) ||
                      (state == ST_DECODE && uop.cls == CLS_HALT);
      if (state == ST_WRITEBACK) begin
        pc <= branch_taken ? pc + uop.imm : pc + 32'd4;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_FETCH && ibus_done) begin
      inst_word <= ibus_rsp.dat;
    end
    if (state == ST_DECODE) begin
      operand_a  <= rs1_data;
      operand_b  <= uop.imm_sel ? uop.imm : rs2_data;
      store_data <= rs2_data;
    end
    if (state == ST_EXECUTE) begin
      result       <= alu_result;
      branch_taken <= (uop.cls == CLS_BRANCH) && (alu_equal != uop.bne);
    end
    // load data replaces the address once the slave answers
    if (state == ST_MEMORY && dbus_done && uop.cls == CLS_LOAD) begin
      result <= dbus_rsp.dat;
    end
  end

  always_comb begin
    ibus_req     = '0;
    ibus_req.adr = pc;
    ibus_req.sel = 4'hf;
    ibus_req.cyc = ibus_cyc;
    ibus_req.stb = ibus_cyc;

    dbus_req     = '0;
    dbus_req.adr = result;
    dbus_req.dat = store_data;
    dbus_req.sel = 4'hf;
    dbus_req.we  = dbus_cyc && (uop.cls == CLS_STORE);
    dbus_req.cyc = dbus_cyc;
    dbus_req.stb = dbus_cyc;
  end

  assign rd_wen   = (state == ST_WRITEBACK) && uop.wen;
  assign rd_idx   = uop.rd;
  assign rd_wdata = result;

  assign retire.valid = retire_valid;
  assign retire.pc    = pc;
  assign retire.rd    = uop.rd;
  assign retire.wdata = uop.wen ? result : '0;
  assign retire.wen   = uop.wen;

  assign halted    = (state == ST_HALT);
  assign bus_error = (state == ST_ERROR);

  // a classic cycle ends the cycle after ack
  a_ibus_drop: assert property (@(posedge clock) disable iff (!rst_n)
    ibus_req.cyc && ibus_rsp.ack |=> !ibus_req.cyc);

  a_dbus_drop: assert property (@(posedge clock) disable iff (!rst_n)
    dbus_req.cyc && dbus_rsp.ack |=> !dbus_req.cyc);

  a_ibus_hold: assert property (@(posedge clock) disable iff (!rst_n)
    ibus_req.cyc && !ibus_rsp.ack && !timeout |=> $stable(ibus_req));

  a_dbus_hold: assert property (@(posedge clock) disable iff (!rst_n)
    dbus_req.cyc && !dbus_rsp.ack && !timeout |=> $stable(dbus_req));

endmodule

`default_nettype wire

//--- core.sv
// ##############################
// core top
// multi-cycle RV32I subset core with wishbone ibus and dbus
// ##############################
`timescale 1ns/1ps
`default_nettype none

module core #(
  parameter core_pkg::xlen_t RESET_PC    = '0,
  parameter int              ACK_TIMEOUT = 16
) (
  input  wire logic              clock,
  input  wire logic              rst_n,
  output core_pkg::wb_req_t      ibus_req,
  input  wire core_pkg::wb_rsp_t ibus_rsp,
  output core_pkg::wb_req_t      dbus_req,
  input  wire core_pkg::wb_rsp_t dbus_rsp,
  output core_pkg::retire_t      retire,
  output logic                   halted,
  output logic                   bus_error
);
  import core_pkg::*;

  xlen_t     inst_word;
  micro_op_t uop;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     operand_a;
  xlen_t     operand_b;
  xlen_t     alu_result;
  logic      alu_equal;
  logic      rd_wen;
  reg_idx_t  rd_idx;
  xlen_t     rd_wdata;
  logic      timeout;

  core_ctrl #(
    .RESET_PC (RESET_PC)
  ) u_ctrl (
    .clock      (clock),
    .rst_n      (rst_n),
    .uop        (uop),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .alu_equal  (alu_equal),
    .ibus_rsp   (ibus_rsp),
    .dbus_rsp   (dbus_rsp),
    .timeout    (timeout),
    .ibus_req   (ibus_req),
    .dbus_req   (dbus_req),
    .inst_word  (inst_word),
    .rd_wen     (rd_wen),
    .rd_idx     (rd_idx),
    .rd_wdata   (rd_wdata),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .retire     (retire),
    .halted     (halted),
    .bus_error  (bus_error)
  );

  // only one bus is ever active, so one watchdog covers both
  bus_watchdog #(
    .ACK_TIMEOUT (ACK_TIMEOUT)
  ) u_watchdog (
    .clock   (clock),
    .rst_n   (rst_n),
    .cyc     (ibus_req.cyc | dbus_req.cyc),
    .ack     (ibus_rsp.ack | dbus_rsp.ack),
    .timeout (timeout)
  );

  inst_decode u_decode (
    .inst_word (inst_word),
    .uop       (uop)
  );

  reg_file u_regs (
    .clock    (clock),
    .rst_n    (rst_n),
    .rs1_idx  (uop.rs1),
    .rs2_idx  (uop.rs2),
    .wen      (rd_wen),
    .rd_idx   (rd_idx),
    .wdata    (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .op     (uop.alu_op),
    .a      (operand_a),
    .b      (operand_b),
    .result (alu_result),
    .equal  (alu_equal)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// ##############################
// testbench clock and reset
// 100 ns clock, reset held low for a few cycles on each restart
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  input  wire logic restart,
  output logic      clock,
  output logic      rst_n
);
  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // reset stays low from time zero until the first restart completes
  initial begin
    rst_n = 1'b0;
    forever begin
      @(posedge restart);
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      rst_n = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- tb_core.sv
// ##############################
// core testbench
// runs the program images from the pattern file against the core,
// serves ibus and dbus and checks retire and store records
// ##############################
`timescale 1ns/1ps
`default_nettype none

module tb_core;
  import core_pkg::*;

  typedef struct packed {
    xlen_t pc;
    xlen_t rd;
    xlen_t val;
  } retire_rec_t;

  typedef struct packed {
    xlen_t adr;
    xlen_t dat;
  } store_rec_t;

  logic        clock;
  logic        rst_n;
  logic        restart;
  wb_req_t     ibus_req;
  wb_rsp_t     ibus_rsp;
  wb_req_t     dbus_req;
  wb_rsp_t     dbus_rsp;
  retire_t     retire;
  logic        halted;
  logic        bus_error;

  xlen_t       pat [0:1023];
  xlen_t       mem [0:4095];
  retire_rec_t exp_retire [$];
  store_rec_t  exp_store [$];
  logic [31:0] rng;
  logic        running;
  logic        test_done;
  logic        test_err;
  logic        hang_dbus;
  xlen_t       end_code;
  int unsigned cycles;
  int unsigned cycle_limit;
  logic        ibus_busy;
  logic        dbus_busy;
  int          ibus_wait;
  int          dbus_wait;
  logic        ending;
  int          tail;

  tb_clock_gen u_clock_gen (
    .restart (restart),
    .clock   (clock),
    .rst_n   (rst_n)
  );

  core #(
    .RESET_PC    (32'h0000_0000),
    .ACK_TIMEOUT (16)
  ) u_dut (
    .clock     (clock),
    .rst_n     (rst_n),
    .ibus_req  (ibus_req),
    .ibus_rsp  (ibus_rsp),
    .dbus_req  (dbus_req),
    .dbus_rsp  (dbus_rsp),
    .retire    (retire),
    .halted    (halted),
    .bus_error (bus_error)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // words taken by each record kind in the pattern file
  function automatic int record_words(input xlen_t kind);
    case (kind)
      32'd1:   return 4;
      32'd2:   return 3;
      32'd3:   return 4;
      32'd4:   return 3;
      32'd5:   return 2;
      default: return 1;
    endcase
  endfunction

  // slave side of both buses plus retire and store checks
  always @(negedge clock) begin : serve_and_check
    retire_rec_t rexp;
    store_rec_t  sexp;
    xlen_t       got_rd;
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end else if (!rst_n || !running) begin
      ibus_rsp.ack = 1'b0;
      dbus_rsp.ack = 1'b0;
      ibus_busy = 1'b0;
      dbus_busy = 1'b0;
    end else begin
      // instruction fetch
      if (ibus_rsp.ack) begin
        ibus_rsp.ack = 1'b0;
        ibus_busy = 1'b0;
      end else if (ibus_req.cyc && ibus_req.stb) begin
        if (!ibus_busy) begin
          ibus_busy = 1'b1;
          rng = xorshift32(rng);
          ibus_wait = int'(rng[1:0]);
        end
        if (ibus_wait == 0) begin
          ibus_rsp.ack = 1'b1;
          ibus_rsp.dat = mem[ibus_req.adr[13:2]];
          if (ibus_req.we !== 1'b0) begin
            $display("error at %0d ns: ibus_req.we = %b, expected 0",
                     $time, ibus_req.we);
            test_err = 1'b1;
          end
          if (ibus_req.sel !== 4'hf) begin
            $display("error at %0d ns: ibus_req.sel = %h, expected f",
                     $time, ibus_req.sel);
            test_err = 1'b1;
          end
        end else begin
          ibus_wait = ibus_wait - 1;
        end
      end
      // data access, left unanswered in the hang test
      if (dbus_rsp.ack) begin
        dbus_rsp.ack = 1'b0;
        dbus_busy = 1'b0;
      end else if (dbus_req.cyc && dbus_req.stb && !hang_dbus) begin
        if (!dbus_busy) begin
          dbus_busy = 1'b1;
          rng = xorshift32(rng);
          dbus_wait = int'(rng[1:0]);
        end
        if (dbus_wait == 0) begin
          dbus_rsp.ack = 1'b1;
          dbus_rsp.dat = mem[dbus_req.adr[13:2]];
          if (dbus_req.sel !== 4'hf) begin
            $display("error at %0d ns: dbus_req.sel = %h, expected f",
                     $time, dbus_req.sel);
            test_err = 1'b1;
          end
          if (dbus_req.we) begin
            mem[dbus_req.adr[13:2]] = dbus_req.dat;
            if (exp_store.size() == 0) begin
              $display("extra store to %h seen at %0d ns", dbus_req.adr, $time);
              test_err = 1'b1;
              ending = 1'b1;
            end else begin
              sexp = exp_store.pop_front();
              if (dbus_req.adr !== sexp.adr) begin
                $display("error at %0d ns: dbus_req.adr = %h, expected %h",
                         $time, dbus_req.adr, sexp.adr);
                test_err = 1'b1;
              end
              if (dbus_req.dat !== sexp.dat) begin
                $display("error at %0d ns: dbus_req.dat = %h, expected %h",
                         $time, dbus_req.dat, sexp.dat);
                test_err = 1'b1;
              end
            end
          end
        end else begin
          dbus_wait = dbus_wait - 1;
        end
      end
      if (retire.valid) begin
        if (exp_retire.size() == 0) begin
          $display("extra retire at pc %h seen at %0d ns", retire.pc, $time);
          test_err = 1'b1;
          ending = 1'b1;
        end else begin
          rexp = exp_retire.pop_front();
          got_rd = retire.wen ? xlen_t'(retire.rd) : '0;
          if (retire.pc !== rexp.pc) begin
            $display("error at %0d ns: retire.pc = %h, expected %h",
                     $time, retire.pc, rexp.pc);
            test_err = 1'b1;
          end
          if (got_rd !== rexp.rd) begin
            $display("error at %0d ns: retire.rd = %h, expected %h",
                     $time, got_rd, rexp.rd);
            test_err = 1'b1;
          end
          if (retire.wdata !== rexp.val) begin
            $display("error at %0d ns: retire.wdata = %h, expected %h",
                     $time, retire.wdata, rexp.val);
            test_err = 1'b1;
          end
        end
      end
      // a few more cycles after the end to catch late records
      if (ending) begin
        tail = tail - 1;
        if (tail == 0) begin
          running = 1'b0;
          test_done = 1'b1;
        end
      end else if (halted || bus_error) begin
        ending = 1'b1;
      end
    end
  end

  initial begin : run_tests
    int          ptr;
    int          pass_count;
    int          fail_count;
    int          n_tests;
    int          n_retires;
    logic        file_bad;
    logic [63:0] name;
    xlen_t       kind;
    restart = 1'b0;
    ibus_rsp = '0;
    dbus_rsp = '0;
    rng = 32'd39883;
    running = 1'b0;
    test_done = 1'b0;
    test_err = 1'b0;
    hang_dbus = 1'b0;
    end_code = '0;
    cycles = 0;
    ibus_busy = 1'b0;
    dbus_busy = 1'b0;
    ibus_wait = 0;
    dbus_wait = 0;
    ending = 1'b0;
    tail = 0;
    pass_count = 0;
    fail_count = 0;
    file_bad = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      pat[i] = 32'hffff_ffff;
    end
    $readmemh("core_patterns.txt", pat);

    // run limit from the length of all tests
    n_tests = 0;
    n_retires = 0;
    ptr = 0;
    while (ptr < 1024 && pat[ptr] != 32'd0) begin
      if (pat[ptr] == 32'd1) begin
        n_tests = n_tests + 1;
      end
      if (pat[ptr] == 32'd3) begin
        n_retires = n_retires + 1;
      end
      ptr = ptr + record_words(pat[ptr]);
    end
    cycle_limit = n_retires * 20 + n_tests * 200;

    ptr = 0;
    while (pat[ptr] == 32'd1 && !file_bad) begin
      name = {pat[ptr+1], pat[ptr+2]};
      hang_dbus = pat[ptr+3][0];
      ptr = ptr + 4;
      exp_retire.delete();
      exp_store.delete();
      for (int i = 0; i < 4096; i++) begin
        mem[i] = xlen_t'(i << 2) ^ 32'h5a5a_0000;
      end
      kind = pat[ptr];
      while (kind != 32'd5 && !file_bad) begin
        case (kind)
          32'd2: mem[pat[ptr+1][13:2]] = pat[ptr+2];
          32'd3: exp_retire.push_back({pat[ptr+1], pat[ptr+2], pat[ptr+3]});
          32'd4: exp_store.push_back({pat[ptr+1], pat[ptr+2]});
          default: begin
            $display("pattern file has an unknown record %h at word %0d", kind, ptr);
            file_bad = 1'b1;
          end
        endcase
        ptr = ptr + record_words(kind);
        kind = pat[ptr];
      end
      end_code = pat[ptr+1];
      ptr = ptr + 2;

      test_err = 1'b0;
      ending = 1'b0;
      tail = 4;
      @(posedge clock);
      restart = 1'b1;
      @(posedge rst_n);
      restart = 1'b0;
      running = 1'b1;
      wait (test_done);
      test_done = 1'b0;

      if (exp_retire.size() != 0) begin
        $display("%0d expected retire records never appeared", exp_retire.size());
        test_err = 1'b1;
      end
      if (exp_store.size() != 0) begin
        $display("%0d expected stores never appeared", exp_store.size());
        test_err = 1'b1;
      end
      if ((end_code == 32'd1 && !halted) || (end_code == 32'd2 && !bus_error)) begin
        $display("core stopped in the wrong state, halted %b bus_error %b",
                 halted, bus_error);
        test_err = 1'b1;
      end
      if (test_err) begin
        fail_count = fail_count + 1;
        $display("test %s: fail", name);
      end else begin
        pass_count = pass_count + 1;
        $display("test %s: pass", name);
      end
    end
    if (pat[ptr] != 32'd0) begin
      $display("pattern file does not end with an end marker");
      file_bad = 1'b1;
    end

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0 && !file_bad) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- core_patterns.txt
// records: 1 name name flags = test start (flag bit 0 never acks dbus)
// 2 addr data = preload, 3 pc rd value = retire, 4 addr data = store, 5 code = end, 0 = eof
1 616c755f 72656773 0
2 0 00500093
2 4 ffd00113
2 8 002081b3
2 c 40208233
2 10 0020f2b3
2 14 0020e333
2 18 0020c3b3
2 1c 00112433
2 20 0020a4b3
2 24 00108033
2 28 00100533
2 2c 00100073
3 0 1 5
3 4 2 fffffffd
3 8 3 2
3 c 4 8
3 10 5 5
3 14 6 fffffffd
3 18 7 fffffff8
3 1c 8 1
3 20 9 0
3 24 0 0
3 28 a 5
3 2c 0 0
5 1
1 61646469 5f6c7569 0
2 0 123450b7
2 4 67808113
2 8 fff00193
2 c fffff237
2 10 80020293
2 14 00100073
3 0 1 12345000
3 4 2 12345678
3 8 3 ffffffff
3 c 4 fffff000
3 10 5 ffffe800
3 14 0 0
5 1
1 6d656d5f 776f7264 0
2 0 000010b7
2 4 12300113
2 8 0020a023
2 c 0010a223
2 10 0000a183
2 14 0040a203
2 18 fe30ae23
2 1c 0080a283
2 20 00100073
2 1008 cafef00d
3 0 1 1000
3 4 2 123
3 8 0 0
3 c 0 0
3 10 3 123
3 14 4 1000
3 18 0 0
3 1c 5 cafef00d
3 20 0 0
4 1000 123
4 1004 1000
4 ffc 123
5 1
1 6272616e 63686573 0
2 0 00300093
2 4 00000113
2 8 00110113
2 c fe111ee3
2 10 00208463
2 14 00700193
2 18 00008463
2 1c 00009463
2 20 00900193
2 24 00100213
2 28 00100073
3 0 1 3
3 4 2 0
3 8 2 1
3 c 0 0
3 8 2 2
3 c 0 0
3 8 2 3
3 c 0 0
3 10 0 0
3 18 0 0
3 1c 0 0
3 24 4 1
3 28 0 0
5 1
1 68616c74 5f696c6c 0
2 0 00100093
2 4 ffffffff
3 0 1 1
5 1
1 6275735f 68616e67 1
2 0 04000093
2 4 0000a103
3 0 1 40
5 2
0

//--- all.f
core_pkg.sv
alu.sv
reg_file.sv
inst_decode.sv
bus_watchdog.sv
core_ctrl.sv
core.sv
tb_clock_gen.sv
tb_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_core
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) core_patterns.txt
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TESTS FAILED" $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
